/* filelist.f */
verilog/sifhPkg.sv
verilog/eventFifo.sv
verilog/histRam.sv
verilog/peakScan.sv
verilog/histController.sv
verilog/sifhCore.sv
testbench/sifhTb_assert.sv
testbench/sifhTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sifhTb \
    -f filelist.f -o sifhSim \
    && ./obj_dir/sifhSim > sim.log 2>&1
cat sim.log
grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/sifhTb.sv */
module sifhTb;
    import sifhPkg::*;

    localparam int TIMEOUT  = 1000;     // cycles allowed per wait
    localparam int ADDR_NUM = PIXEL_NUM * BIN_NUM;

    logic   clk;
    logic   res;
    event_t inEvent;
    logic   inValid;
    logic   creditReturn;
    peak_t  peakOut;
    logic   peakValid;

    int sentCnt     = 0;    // words sent at one credit each
    int returnedCnt = 0;
    int model [ADDR_NUM];   // expected count per pixel and bin

    sifhCore i_sifhCore (
        .clk          (clk),
        .res          (res),
        .inEvent      (inEvent),
        .inValid      (inValid),
        .creditReturn (creditReturn),
        .peakOut      (peakOut),
        .peakValid    (peakValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (creditReturn) begin
            returnedCnt = returnedCnt + 1;
        end
    end

    function automatic int creditsLeft();
        return FIFO_DEPTH - sentCnt + returnedCnt;
    endfunction

    function automatic void clearModel();
        for (int a = 0; a < ADDR_NUM; a++) begin
            model[a] = 0;
        end
    endfunction

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped after the first error");
    endtask

    // RAM is wiped by the sweep that follows reset
    task automatic applyReset();
        res     = 1'b0;
        inValid = 1'b0;
        inEvent = '0;
        repeat (5) @(negedge clk);
        res = 1'b1;
        clearModel();
    endtask

    // blocks until upstream holds a credit
    task automatic sendEvent(input event_t ev);
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (creditsLeft() == 0) begin
            inValid = 1'b0;
            waitCnt++;
            if (waitCnt > TIMEOUT) begin
                stopRun("timeout while waiting for an input credit");
            end
            @(negedge clk);
        end
        inEvent = ev;
        inValid = 1'b1;
        sentCnt++;
    endtask

    task automatic releaseBus();
        @(negedge clk);
        inValid = 1'b0;
        inEvent = '0;
    endtask

    task automatic waitCredits(input string testName);
        int waitCnt;
        waitCnt = 0;
        while (creditsLeft() != FIFO_DEPTH) begin
            waitCnt++;
            if (waitCnt > TIMEOUT) begin
                stopRun($sformatf("%s: input credits did not all come back", testName));
            end
            @(negedge clk);
        end
    endtask

    task automatic sendHit(input int pixel, input int bin);
        event_t ev;
        int     addr;
        ev                   = '0;
        ev.payload.hit.pixel = PIXEL_W'(pixel);
        ev.payload.hit.bin   = BIN_W'(bin);
        addr                 = pixel * BIN_NUM + bin;
        if (model[addr] < 255) begin    // counts stick at the top
            model[addr]++;
        end
        sendEvent(ev);
    endtask

    task automatic sendCmd(input cmd_e cmd);
        event_t ev;
        ev                       = '0;
        ev.isCmd                 = 1'b1;
        ev.payload.command.cmd   = cmd;
        if (cmd == CLEAR) begin
            clearModel();   // earlier hits are counted first and then wiped
        end
        sendEvent(ev);
    endtask

    // highest count of one pixel with the lowest bin on a tie
    function automatic peak_t expectedPeak(input int pixel);
        peak_t p;
        int    bestBin;
        int    bestCount;
        bestBin   = 0;
        bestCount = 0;
        for (int b = 0; b < BIN_NUM; b++) begin
            if (model[pixel * BIN_NUM + b] > bestCount) begin
                bestBin   = b;
                bestCount = model[pixel * BIN_NUM + b];
            end
        end
        p.pixel = PIXEL_W'(pixel);
        p.bin   = BIN_W'(bestBin);
        p.count = COUNT_W'(bestCount);
        return p;
    endfunction

    task automatic checkPeak(input string testName, input peak_t expected,
                             input peak_t actual);
        if (actual !== expected) begin
            stopRun($sformatf("FAILED %s: expected pixel %0d bin %0d count %0d, %s",
                testName, expected.pixel, expected.bin, expected.count,
                $sformatf("actual pixel %0d bin %0d count %0d",
                    actual.pixel, actual.bin, actual.count)));
        end
    endtask

    task automatic checkCredits(input string testName);
        int actual;
        actual = creditsLeft();
        if (actual != FIFO_DEPTH) begin
            stopRun($sformatf("FAILED %s: expected %0d credits, actual %0d",
                testName, FIFO_DEPTH, actual));
        end
    endtask

    task automatic findPeaks(input string testName);
        peak_t expected [PIXEL_NUM];
        int    waitCnt;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expected[p] = expectedPeak(p);
        end
        sendCmd(FIND_PEAKS);
        releaseBus();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            waitCnt = 0;
            @(negedge clk);
            while (!peakValid) begin
                waitCnt++;
                if (waitCnt > TIMEOUT) begin
                    stopRun($sformatf("%s: no peak result for pixel %0d", testName, p));
                end
                @(negedge clk);
            end
            checkPeak(testName, expected[p], peakOut);   // results in pixel order
        end
    endtask

    // RAM words survive reset and only the clear sweep wipes these hits
    task automatic testResetClear();
        repeat (20) sendHit($urandom % PIXEL_NUM, $urandom % BIN_NUM);
        releaseBus();
        waitCredits("resetClear");
        applyReset();
        findPeaks("resetClear");
        checkCredits("resetClear");
    endtask

    task automatic testRandomHits();
        for (int i = 0; i < 300; i++) begin
            sendHit($urandom % PIXEL_NUM, $urandom % BIN_NUM);
        end
        findPeaks("randomHits");
        checkCredits("randomHits");
    endtask

    // same bin twice in a row and two bins interleaved
    task automatic testForwarding();
        sendCmd(CLEAR);
        repeat (8) sendHit(0, 5);
        repeat (6) begin
            sendHit(1, 7);
            sendHit(2, 33);
        end
        repeat (3) begin
            sendHit(3, 60);
            sendHit(3, 60);
            sendHit(3, 2);
        end
        findPeaks("forwarding");
        checkCredits("forwarding");
    endtask

    task automatic testSaturation();
        repeat (300) sendHit(2, 40);
        findPeaks("saturation");
        checkCredits("saturation");
    endtask

    task automatic testClearCmd();
        for (int i = 0; i < 40; i++) begin
            sendHit($urandom % PIXEL_NUM, $urandom % BIN_NUM);
        end
        sendCmd(CLEAR);
        findPeaks("clearCmd");
        checkCredits("clearCmd");
    endtask

    initial begin
        void'($urandom(32'hfd7b_9c84));
        applyReset();

        testResetClear();
        testRandomHits();
        testForwarding();
        testSaturation();
        testClearCmd();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* testbench/sifhTb_assert.sv */
module flowChecks (
    input logic clk,
    input logic res,
    input logic pushFull,       // push attempted with no free entry
    input logic popEmpty,
    input logic writeInScan,
    input logic peakPulse
);

    noPushWhenFull: assert property (@(posedge clk) disable iff (!res) !pushFull)
        else $error("word pushed into a full FIFO");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!res) !popEmpty)
        else $error("pop requested from an empty FIFO");

    noWriteInScan: assert property (@(posedge clk) disable iff (!res) !writeInScan)
        else $error("RAM write during the peak scan");

    // results are single-cycle pulses
    singlePeakPulse: assert property (@(posedge clk) disable iff (!res)
        peakPulse |=> !peakPulse)
        else $error("peakValid high on two consecutive cycles");

endmodule

bind eventFifo flowChecks i_fifoChecks (
    .clk         (clk),
    .res         (res),
    .pushFull    (inValid && fill == sifhPkg::FIFO_DEPTH),
    .popEmpty    (fifoPop && !fifoNotEmpty),
    .writeInScan (1'b0),
    .peakPulse   (1'b0)
);

bind histController flowChecks i_ctrlChecks (
    .clk         (clk),
    .res         (res),
    .pushFull    (1'b0),
    .popEmpty    (1'b0),
    .writeInScan (writeEnable && state == ST_SCAN),
    .peakPulse   (peakValid)
);

/* verilog/eventFifo.sv */
module eventFifo (
    input  logic            clk,
    input  logic            res,
    input  sifhPkg::event_t inEvent,
    input  logic            inValid,
    input  logic            fifoPop,
    output sifhPkg::event_t fifoEvent,
    output logic            fifoNotEmpty,
    output logic            creditReturn
);
    import sifhPkg::*;

    event_t                          mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wrPtr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rdPtr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] fill;
    logic                            push;
    logic                            pop;

    // upstream only sends with a credit, the full check is a safety net
    assign push = inValid && (fill != FIFO_DEPTH);
    assign pop  = fifoPop && fifoNotEmpty;

    assign fifoEvent    = mem[rdPtr];   // show-ahead
    assign fifoNotEmpty = fill != '0;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inEvent;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            fill         <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            creditReturn <= pop;    // one credit back per word consumed
        end
    end

endmodule

/* verilog/histController.sv */
module histController (
    input  logic            clk,
    input  logic            res,
    input  sifhPkg::event_t fifoEvent,
    input  logic            fifoNotEmpty,
    output logic            fifoPop,
    output sifhPkg::peak_t  peakOut,
    output logic            peakValid
);
    import sifhPkg::*;

    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_ACCUM,
        ST_DRAIN,
        ST_SCAN
    } state_e;

    state_e             state;
    state_e             nextState;
    logic [ADDR_W-1:0]  addrCnt;        // shared by clear and scan sweeps
    logic               addrLast;
    hitView_t           hit;
    cmd_e               cmd;
    logic               hitPop;
    logic               cmdPop;
    logic [ADDR_W-1:0]  hitAddr;
    logic               s1Valid;        // hit waiting for its read data
    logic [ADDR_W-1:0]  s1Addr;
    logic               s1Fwd;
    logic [COUNT_W-1:0] fwdData;
    logic [COUNT_W-1:0] oldCount;
    logic [COUNT_W-1:0] hitCount;
    logic               writeEnable;
    logic [ADDR_W-1:0]  writeAddr;
    logic [COUNT_W-1:0] writeData;
    logic               readEnable;
    logic [ADDR_W-1:0]  readAddr;
    logic [COUNT_W-1:0] readData;
    logic               scanValid;
    logic [ADDR_W-1:0]  scanAddr;

    // same word, two views
    assign hit     = fifoEvent.payload.hit;
    assign cmd     = fifoEvent.payload.command.cmd;
    assign hitAddr = {hit.pixel, hit.bin};

    assign fifoPop  = (state == ST_ACCUM) && fifoNotEmpty;
    assign hitPop   = fifoPop && !fifoEvent.isCmd;
    assign cmdPop   = fifoPop && fifoEvent.isCmd;
    assign addrLast = addrCnt == ADDR_W'(PIXEL_NUM * BIN_NUM - 1);

    always_comb begin
        nextState = state;
        case (state)
            ST_CLEAR: begin
                if (addrLast) begin
                    nextState = ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (cmdPop && cmd == CLEAR) begin
                    nextState = ST_CLEAR;
                end else if (cmdPop && cmd == FIND_PEAKS) begin
                    nextState = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (!s1Valid) begin     // last hit write is out
                    nextState = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (addrLast) begin
                    nextState = ST_ACCUM;
                end
            end
            default: nextState = ST_ACCUM;
        endcase
    end

    // reset starts with a full clear sweep
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= ST_CLEAR;
            addrCnt   <= '0;
            s1Valid   <= 1'b0;
            s1Fwd     <= 1'b0;
            scanValid <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState != state) begin
                addrCnt <= '0;          // every sweep starts at address 0
            end else if (state == ST_CLEAR || state == ST_SCAN) begin
                addrCnt <= addrCnt + 1'b1;
            end
            s1Valid   <= hitPop;
            s1Fwd     <= hitPop && s1Valid && (hitAddr == s1Addr);
            scanValid <= state == ST_SCAN;  // lines up with readData
        end
    end

    always_ff @(posedge clk) begin
        if (hitPop) begin
            s1Addr <= hitAddr;
        end
        fwdData  <= hitCount;           // value being written this cycle
        scanAddr <= addrCnt;
    end

    // read data is stale when the previous hit wrote the same bin
    assign oldCount = s1Fwd ? fwdData : readData;
    assign hitCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;

    assign writeEnable = (state == ST_CLEAR) || s1Valid;
    assign writeAddr   = (state == ST_CLEAR) ? addrCnt : s1Addr;
    assign writeData   = (state == ST_CLEAR) ? '0 : hitCount;
    assign readEnable  = hitPop || (state == ST_SCAN);
    assign readAddr    = (state == ST_SCAN) ? addrCnt : hitAddr;

    histRam i_histRam (
        .clk         (clk),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .readEnable  (readEnable),
        .readAddr    (readAddr),
        .readData    (readData)
    );

    peakScan i_peakScan (
        .clk       (clk),
        .res       (res),
        .scanValid (scanValid),
        .scanAddr  (scanAddr),
        .readData  (readData),
        .peakOut   (peakOut),
        .peakValid (peakValid)
    );

endmodule

/* verilog/histRam.sv */
module histRam (
    input  logic                        clk,
    input  logic                        writeEnable,
    input  logic [sifhPkg::ADDR_W-1:0]  writeAddr,
    input  logic [sifhPkg::COUNT_W-1:0] writeData,
    input  logic                        readEnable,
    input  logic [sifhPkg::ADDR_W-1:0]  readAddr,
    output logic [sifhPkg::COUNT_W-1:0] readData
);
    import sifhPkg::*;

    // one word per pixel and bin
    logic [COUNT_W-1:0] mem [PIXEL_NUM*BIN_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // read port, one cycle latency
    // same-address read and write in one cycle returns the old word,
    // the controller forwards around that case
    always_ff @(posedge clk) begin
        if (readEnable) begin
            readData <= mem[readAddr];
        end
    end

endmodule

/* verilog/peakScan.sv */
module peakScan (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        scanValid,
    input  logic [sifhPkg::ADDR_W-1:0]  scanAddr,
    input  logic [sifhPkg::COUNT_W-1:0] readData,
    output sifhPkg::peak_t              peakOut,
    output logic                        peakValid
);
    import sifhPkg::*;

    logic [PIXEL_W-1:0] scanPixel;
    logic [BIN_W-1:0]   scanBin;
    logic [BIN_W-1:0]   bestBin;        // running maximum of current pixel
    logic [COUNT_W-1:0] bestCount;
    logic               better;
    logic               lastBin;
    logic [BIN_W-1:0]   nextBin;
    logic [COUNT_W-1:0] nextCount;

    assign {scanPixel, scanBin} = scanAddr;

    // strictly greater, so ties keep the lower bin
    assign better  = readData > bestCount;
    assign lastBin = scanBin == BIN_W'(BIN_NUM - 1);

    assign nextBin   = better ? scanBin : bestBin;
    assign nextCount = better ? readData : bestCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bestBin   <= '0;
            bestCount <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanValid && lastBin;  // one pulse per pixel
            if (scanValid) begin
                if (lastBin) begin
                    // next pixel starts from bin 0, count 0
                    bestBin   <= '0;
                    bestCount <= '0;
                end else begin
                    bestBin   <= nextBin;
                    bestCount <= nextCount;
                end
            end
        end
    end

    // result includes the last bin itself
    always_ff @(posedge clk) begin
        if (scanValid && lastBin) begin
            peakOut.pixel <= scanPixel;
            peakOut.bin   <= nextBin;
            peakOut.count <= nextCount;
        end
    end

endmodule

/* verilog/sifhCore.sv */
module sifhCore (
    input  logic            clk,
    input  logic            res,
    input  sifhPkg::event_t inEvent,
    input  logic            inValid,
    output logic            creditReturn,
    output sifhPkg::peak_t  peakOut,
    output logic            peakValid
);
    import sifhPkg::*;

    event_t fifoEvent;
    logic   fifoNotEmpty;
    logic   fifoPop;

    // credit-based input buffer
    eventFifo i_eventFifo (
        .clk          (clk),
        .res          (res),
        .inEvent      (inEvent),
        .inValid      (inValid),
        .fifoPop      (fifoPop),
        .fifoEvent    (fifoEvent),
        .fifoNotEmpty (fifoNotEmpty),
        .creditReturn (creditReturn)
    );

    // histogram FSM, RAM and peak finder
    histController i_histController (
        .clk          (clk),
        .res          (res),
        .fifoEvent    (fifoEvent),
        .fifoNotEmpty (fifoNotEmpty),
        .fifoPop      (fifoPop),
        .peakOut      (peakOut),
        .peakValid    (peakValid)
    );

endmodule

/* verilog/sifhPkg.sv */
package sifhPkg;

    localparam int PIXEL_NUM  = 4;
    localparam int BIN_NUM    = 64;                 // time bins per pixel
    localparam int PIXEL_W    = 2;
    localparam int BIN_W      = 6;
    localparam int ADDR_W     = PIXEL_W + BIN_W;    // pixel in the upper bits
    localparam int COUNT_W    = 8;                  // saturates at all ones
    localparam int FIFO_DEPTH = 4;                  // = credits held upstream after reset

    typedef enum logic [1:0] {
        NOP        = 2'd0,
        CLEAR      = 2'd1,
        FIND_PEAKS = 2'd2
    } cmd_e;

    // payload seen as a hit
    typedef struct packed {
        logic [PIXEL_W-1:0] pixel;
        logic [BIN_W-1:0]   bin;
    } hitView_t;

    // payload seen as a command
    typedef struct packed {
        cmd_e       cmd;
        logic [5:0] reserved;
    } cmdView_t;

    typedef union packed {
        hitView_t hit;
        cmdView_t command;
    } eventPayload_u;

    typedef struct packed {
        logic          isCmd;       // selects the union view
        eventPayload_u payload;
    } event_t;

    typedef struct packed {
        logic [PIXEL_W-1:0] pixel;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } peak_t;

endpackage
